// File: sim.f
common/video_pkg.sv
video_timing/video_timing.sv
video_regs/video_regs.sv
rtl/bitmap_fetch.sv
rtl/video_gen.sv
verif/video_gen_checker.sv
verif/video_gen_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video core simulation with Verilator
set -e
set -o pipefail 2>/dev/null || true

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module video_gen_tb -f sim.f -o video_gen_sim

./obj_dir/video_gen_sim 2>&1 | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

// File: verif/video_gen_tb.sv
// video_gen_tb
// Directed tests for the video core in a small 16x6 mode: register
// readback, sync timing, bitmap pixels, window and blank, interrupts
// and the scanline status register.

`timescale 1ns/1ps

module video_gen_tb;
    import video_pkg::*;

    localparam int FRAME   = 24 * 10;           // cycles per frame
    localparam int TIMEOUT = 4 * FRAME;

    logic       clk, reset_i, reg_wr_en_i;
    reg_num_t   reg_num_i;
    vword_t     reg_data_i, reg_data_o;
    logic [3:0] intr_status_i, intr_signal_o;
    logic       vram_sel_o, hsync_o, vsync_o, dv_de_o;
    vaddr_t     vram_addr_o;
    vword_t     vram_data_i = '0;
    color_t     color_index_o;

    vword_t vram [0:65535];
    integer seed;
    int     errors, checks;

    // expected register state
    color_t exp_border, exp_base;
    logic   exp_blank;
    coord_t exp_left, exp_right, exp_top, exp_bottom;
    vaddr_t exp_start, exp_len;

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram[vram_addr_o];   // one cycle read latency
        end
    end

    video_gen #(
        .H_VISIBLE(16), .H_FRONT(2), .H_SYNC(3), .H_BACK(3),
        .V_VISIBLE(6), .V_FRONT(1), .V_SYNC(2), .V_BACK(1),
        .H_SYNC_POL(1'b0), .V_SYNC_POL(1'b0)
    ) u_dut (
        .clk(clk), .reset_i(reset_i), .reg_wr_en_i(reg_wr_en_i),
        .reg_num_i(reg_num_i), .reg_data_i(reg_data_i), .reg_data_o(reg_data_o),
        .intr_status_i(intr_status_i), .intr_signal_o(intr_signal_o),
        .vram_sel_o(vram_sel_o), .vram_addr_o(vram_addr_o), .vram_data_i(vram_data_i),
        .color_index_o(color_index_o), .hsync_o(hsync_o), .vsync_o(vsync_o),
        .dv_de_o(dv_de_o)
    );

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen in time", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic write_reg(input reg_num_t n, input vword_t d);
        @(posedge clk);
        reg_wr_en_i <= 1'b1;
        reg_num_i   <= n;
        reg_data_i  <= d;
        @(posedge clk);
        reg_wr_en_i <= 1'b0;
        case (n)
            XR_VID_CTRL:     exp_border = d[15:8];
            XR_VID_LEFT:     exp_left   = d[10:0];
            XR_VID_RIGHT:    exp_right  = d[10:0];
            XR_VID_TOP:      exp_top    = d[10:0];
            XR_VID_BOTTOM:   exp_bottom = d[10:0];
            XR_PA_GFX_CTRL: begin
                exp_base  = d[15:8];
                exp_blank = d[7];
            end
            XR_PA_DISP_ADDR: exp_start  = d;
            XR_PA_LINE_LEN:  exp_len    = d;
            default: begin
            end
        endcase
    endtask

    task automatic read_check(input string name, input reg_num_t n, input vword_t exp);
        @(posedge clk);
        reg_num_i <= n;
        @(posedge clk);
        @(negedge clk);
        check_value(name, exp, reg_data_o);
    endtask

    // 0 hsync active, 1 display enable, 2 vsync active
    function automatic logic probe(input int sel);
        case (sel)
            0:       return !hsync_o;
            1:       return dv_de_o;
            default: return !vsync_o;
        endcase
    endfunction

    task automatic wait_rise(input int sel, output int n);
        logic prev;
        n    = 0;
        prev = probe(sel);
        forever begin
            @(negedge clk);
            n++;
            if (!prev && probe(sel)) break;
            if (n >= TIMEOUT) abort_on_timeout("signal rise");
            prev = probe(sel);
        end
    endtask

    task automatic count_high(input int sel, output int n);
        n = 0;
        while (probe(sel)) begin
            n++;
            if (n >= TIMEOUT) abort_on_timeout("signal fall");
            @(negedge clk);
        end
    endtask

    function automatic color_t expect_pixel(input int x, input int y);
        vaddr_t addr;
        vword_t w;
        color_t b;
        if (exp_blank || x < exp_left || x >= exp_right || y < exp_top || y >= exp_bottom)
            return exp_border;
        addr = exp_start + vaddr_t'((y - exp_top) * exp_len) + vaddr_t'((x - exp_left) / 2);
        w    = vram[addr];
        b    = ((x - exp_left) % 2 == 0) ? w[15:8] : w[7:0];   // even pixel in high byte
        return b ^ exp_base;
    endfunction

    task automatic check_frame(input string name);
        int idx;
        int n;
        wait_rise(2, n);                        // new start address loads after vsync
        idx = 0;
        n   = 0;
        while (idx < 96) begin
            @(negedge clk);
            n++;
            if (n >= TIMEOUT) abort_on_timeout("enabled pixels of a frame");
            if (dv_de_o) begin
                check_value(name, 16'(expect_pixel(idx % 16, idx / 16)), 16'(color_index_o));
                idx++;
            end
        end
    endtask

    task automatic test_reset_readback();
        read_check("rst_ctrl", XR_VID_CTRL, 16'h0803);
        read_check("rst_left", XR_VID_LEFT, 16'd0);
        read_check("rst_right", XR_VID_RIGHT, 16'd16);
        read_check("rst_top", XR_VID_TOP, 16'd0);
        read_check("rst_bottom", XR_VID_BOTTOM, 16'd6);
        read_check("hsize", XR_VID_HSIZE, 16'd16);
        read_check("vsize", XR_VID_VSIZE, 16'd6);
        read_check("rst_gfx", XR_PA_GFX_CTRL, 16'h0000);
        read_check("rst_addr", XR_PA_DISP_ADDR, 16'h0000);
        read_check("rst_len", XR_PA_LINE_LEN, 16'd8);
        read_check("unused", 5'd20, 16'h0000);
        write_reg(XR_VID_CTRL, 16'hA5F0);
        read_check("wr_ctrl", XR_VID_CTRL, 16'hA503);
        write_reg(XR_VID_LEFT, 16'hFFFF);
        read_check("wr_left", XR_VID_LEFT, 16'h07FF);
        write_reg(XR_VID_RIGHT, 16'hF80D);
        read_check("wr_right", XR_VID_RIGHT, 16'h000D);
        write_reg(XR_VID_TOP, 16'h8402);
        read_check("wr_top", XR_VID_TOP, 16'h0402);
        write_reg(XR_VID_BOTTOM, 16'h0123);
        read_check("wr_bottom", XR_VID_BOTTOM, 16'h0123);
        write_reg(XR_PA_GFX_CTRL, 16'h3CFF);
        read_check("wr_gfx", XR_PA_GFX_CTRL, 16'h3C80);
        write_reg(XR_PA_DISP_ADDR, 16'h1234);
        read_check("wr_addr", XR_PA_DISP_ADDR, 16'h1234);
        write_reg(XR_PA_LINE_LEN, 16'h0009);
        read_check("wr_len", XR_PA_LINE_LEN, 16'h0009);
        write_reg(XR_VID_CTRL, 16'h0800);
        write_reg(XR_VID_LEFT, 16'd0);
        write_reg(XR_VID_RIGHT, 16'd16);
        write_reg(XR_VID_TOP, 16'd0);
        write_reg(XR_VID_BOTTOM, 16'd6);
        write_reg(XR_PA_GFX_CTRL, 16'h0000);
    endtask

    task automatic test_sync_timing();
        int high, low, lines, n;
        logic prev;
        wait_rise(0, n);
        count_high(0, high);
        wait_rise(0, low);
        check_value("hsync_width", 16'd3, 16'(high));
        check_value("line_period", 16'd24, 16'(high + low));
        wait_rise(1, n);
        count_high(1, high);
        check_value("de_width", 16'd16, 16'(high));
        wait_rise(2, n);
        count_high(2, high);
        check_value("vsync_width", 16'd48, 16'(high));
        lines = 0;
        n     = 0;
        prev  = dv_de_o;
        while (!probe(2)) begin
            @(negedge clk);
            n++;
            if (n >= TIMEOUT) abort_on_timeout("next vsync");
            if (!prev && dv_de_o) lines++;
            prev = dv_de_o;
        end
        check_value("de_lines", 16'd6, 16'(lines));
    endtask

    task automatic test_bitmap();
        write_reg(XR_PA_DISP_ADDR, 16'h0140);
        write_reg(XR_PA_LINE_LEN, 16'd8);
        write_reg(XR_PA_GFX_CTRL, 16'h5A00);
        check_frame("bitmap");
    endtask

    task automatic test_window_blank();
        write_reg(XR_VID_LEFT, 16'd4);
        write_reg(XR_VID_RIGHT, 16'd12);
        write_reg(XR_VID_TOP, 16'd1);
        write_reg(XR_VID_BOTTOM, 16'd5);
        check_frame("window");
        write_reg(XR_PA_GFX_CTRL, 16'h5A80);
        check_frame("blank");
        write_reg(XR_PA_GFX_CTRL, 16'h5A00);
        write_reg(XR_VID_LEFT, 16'd0);
        write_reg(XR_VID_RIGHT, 16'd16);
        write_reg(XR_VID_TOP, 16'd0);
        write_reg(XR_VID_BOTTOM, 16'd6);
    endtask

    task automatic test_interrupts();
        int pulses, n;
        logic [3:0] seen;
        n = 0;
        while (!intr_signal_o[3]) begin
            @(negedge clk);
            n++;
            if (n >= TIMEOUT) abort_on_timeout("frame interrupt");
        end
        write_reg(XR_VID_CTRL, 16'h0805);       // well clear of the next frame pulse
        pulses = 0;
        seen   = '0;
        repeat (20) begin
            @(negedge clk);
            if (intr_signal_o != 4'b0) begin
                pulses++;
                seen = intr_signal_o;
            end
        end
        check_value("sw_intr_count", 16'd1, 16'(pulses));
        check_value("sw_intr_bits", 16'b0101, 16'(seen));
        pulses = 0;
        repeat (FRAME + FRAME / 2) begin
            @(negedge clk);
            if (intr_signal_o[3]) pulses++;
        end
        check_value("frame_intr_count", 16'd1, 16'(pulses));
    endtask

    task automatic test_scanline();
        int vblank_seen;
        @(posedge clk);
        reg_num_i <= XR_SCANLINE;
        @(posedge clk);
        vblank_seen = 0;
        repeat (FRAME + 24) begin
            @(negedge clk);
            if (reg_data_o[10:0] >= 11'd6) begin
                check_value("scanline_vblank", 16'd1, 16'(reg_data_o[15]));
            end
            if (reg_data_o[15]) vblank_seen++;
        end
        check_value("scanline_seen", 16'd1, 16'(vblank_seen > 0));
    endtask

    initial begin
        clk           = 1'b0;
        reset_i       = 1'b1;
        reg_wr_en_i   = 1'b0;
        reg_num_i     = '0;
        reg_data_i    = '0;
        intr_status_i = 4'h3;
        errors        = 0;
        checks        = 0;
        seed          = 32'h920b;
        for (int i = 0; i < 65536; i++) begin
            vram[i] = vword_t'($random(seed));
        end
        exp_border = 8'h08;
        exp_base   = '0;
        exp_blank  = 1'b0;
        exp_left   = '0;
        exp_right  = 11'd16;
        exp_top    = '0;
        exp_bottom = 11'd6;
        exp_start  = '0;
        exp_len    = 16'd8;

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        test_reset_readback();
        test_sync_timing();
        test_bitmap();
        test_window_blank();
        test_interrupts();
        test_scanline();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/video_gen_checker.sv
// video_gen_checker
// Concurrent assertions on the video core outputs, bound to video_gen.

`timescale 1ns/1ps

module video_gen_checker #(
    parameter bit H_POL = 1'b0,
    parameter bit V_POL = 1'b0
) (
    input logic       clk,
    input logic       reset_i,
    input logic       hsync_o,
    input logic       vsync_o,
    input logic       dv_de_o,
    input logic [3:0] intr_signal_o,
    input logic       vram_sel_o
);

    // no display enable inside a sync pulse
    de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_o |-> (hsync_o != H_POL) && (vsync_o != V_POL))
        else $error("display enable high during sync");

    // frame interrupt is a single cycle pulse
    vblank_pulse_single: assert property (@(posedge clk) disable iff (reset_i)
        intr_signal_o[3] |=> !intr_signal_o[3])
        else $error("frame interrupt held for two cycles");

    no_fetch_in_reset: assert property (@(posedge clk)
        (reset_i && $past(reset_i)) |-> !vram_sel_o)
        else $error("video RAM select high during reset");

endmodule

bind video_gen video_gen_checker #(
    .H_POL(H_SYNC_POL),
    .V_POL(V_SYNC_POL)
) u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o),
    .dv_de_o       (dv_de_o),
    .intr_signal_o (intr_signal_o),
    .vram_sel_o    (vram_sel_o)
);

// File: rtl/video_gen.sv
// video_gen
// Top of the display core. Ties the sync timing generator, the
// configuration register bank and the 8 bpp bitmap fetch together.
// Mode timing and sync polarity are set here and handed down.

`timescale 1ns/1ps

module video_gen #(
    parameter int H_VISIBLE  = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,            // 0 means active low
    parameter bit V_SYNC_POL = 1'b0
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                reg_wr_en_i,
    input  video_pkg::reg_num_t reg_num_i,
    input  video_pkg::vword_t   reg_data_i,
    output video_pkg::vword_t   reg_data_o,
    input  logic [3:0]          intr_status_i,
    output logic [3:0]          intr_signal_o,
    output logic                vram_sel_o,
    output video_pkg::vaddr_t   vram_addr_o,
    input  video_pkg::vword_t   vram_data_i,
    output video_pkg::color_t   color_index_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);
    import video_pkg::*;

    scan_pos_t scan_pos;                        // live counter position
    pf_cfg_t   pf_cfg;                          // playfield settings

    video_timing #(
        .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .H_SYNC_POL(H_SYNC_POL), .V_SYNC_POL(V_SYNC_POL)
    ) u_timing (
        .clk        (clk),
        .reset_i    (reset_i),
        .scan_pos_o (scan_pos),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .dv_de_o    (dv_de_o)
    );

    video_regs #(
        .H_VISIBLE(H_VISIBLE),
        .V_VISIBLE(V_VISIBLE)
    ) u_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .reg_wr_en_i   (reg_wr_en_i),
        .reg_num_i     (reg_num_i),
        .reg_data_i    (reg_data_i),
        .intr_status_i (intr_status_i),
        .scan_pos_i    (scan_pos),
        .reg_data_o    (reg_data_o),
        .intr_signal_o (intr_signal_o),
        .pf_cfg_o      (pf_cfg)
    );

    bitmap_fetch u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .scan_pos_i    (scan_pos),
        .pf_cfg_i      (pf_cfg),
        .vram_data_i   (vram_data_i),
        .vram_sel_o    (vram_sel_o),
        .vram_addr_o   (vram_addr_o),
        .color_index_o (color_index_o)
    );

endmodule

// File: rtl/bitmap_fetch.sv
// bitmap_fetch
// 8 bpp bitmap playfield. Requests one video RAM word per pixel pair a
// cycle ahead of the counters, so the colour for a position comes out two
// cycles after the counters held it. Pixels outside the window, or with
// blank set, show the border colour.

`timescale 1ns/1ps

module bitmap_fetch (
    input  logic                 clk,
    input  logic                 reset_i,
    input  video_pkg::scan_pos_t scan_pos_i,
    input  video_pkg::pf_cfg_t   pf_cfg_i,
    input  video_pkg::vword_t    vram_data_i,
    output logic                 vram_sel_o,
    output video_pkg::vaddr_t    vram_addr_o,
    output video_pkg::color_t    color_index_o
);
    import video_pkg::*;

    coord_t nx, ny;                             // position the counters move to next
    coord_t rel_x;                              // nx relative to window left
    logic   y_in_win, nx_in_win, req;
    vaddr_t line_base_q, base_nxt;
    logic   in_win_q, odd_q;                    // stage with the read in flight
    logic   in_win_q2, odd_q2, rd_q;            // stage with read data present
    vword_t word_q;                             // pair held for the odd pixel
    color_t pix;

    always_comb begin
        nx = scan_pos_i.h_count + coord_t'(1);
        ny = scan_pos_i.v_count;
        if (scan_pos_i.line_end) begin
            nx = '0;
            ny = scan_pos_i.frame_end ? '0 : scan_pos_i.v_count + coord_t'(1);
        end
        rel_x     = nx - pf_cfg_i.win_left;
        y_in_win  = (scan_pos_i.v_count >= pf_cfg_i.win_top)
                 && (scan_pos_i.v_count < pf_cfg_i.win_bottom);
        nx_in_win = (nx >= pf_cfg_i.win_left) && (nx < pf_cfg_i.win_right)
                 && (ny >= pf_cfg_i.win_top) && (ny < pf_cfg_i.win_bottom);
        req       = nx_in_win && !pf_cfg_i.blank && !rel_x[0];   // even pixel of a pair

        // line base steps once per finished window line
        base_nxt = line_base_q;
        if (scan_pos_i.frame_end) begin
            base_nxt = pf_cfg_i.start_addr;
        end else if (scan_pos_i.line_end && y_in_win) begin
            base_nxt = line_base_q + pf_cfg_i.line_len;
        end

        pix = odd_q2 ? word_q[7:0] : vram_data_i[15:8];          // high byte is even pixel
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_base_q <= pf_cfg_i.start_addr;
        end else begin
            line_base_q <= base_nxt;
        end
        vram_addr_o <= base_nxt + vaddr_t'(rel_x[10:1]);
        if (rd_q) begin
            word_q <= vram_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel_o    <= 1'b0;
            in_win_q      <= 1'b0;
            odd_q         <= 1'b0;
            in_win_q2     <= 1'b0;
            odd_q2        <= 1'b0;
            rd_q          <= 1'b0;
            color_index_o <= '0;
        end else begin
            vram_sel_o <= req;
            in_win_q   <= nx_in_win;
            odd_q      <= rel_x[0];
            rd_q       <= vram_sel_o;           // data is on the bus next cycle
            in_win_q2  <= in_win_q;
            odd_q2     <= odd_q;
            if (in_win_q2 && !pf_cfg_i.blank) begin
                color_index_o <= pix ^ pf_cfg_i.colorbase;
            end else begin
                color_index_o <= pf_cfg_i.border;
            end
        end
    end

endmodule

// File: video_regs/video_regs.sv
// video_regs
// Configuration register bank. Decodes writes into the playfield
// settings, returns the selected register one cycle after the number is
// presented, and pulses the interrupt outputs on a control write and at
// the end of the visible frame.

`timescale 1ns/1ps

module video_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 reg_wr_en_i,
    input  video_pkg::reg_num_t  reg_num_i,
    input  video_pkg::vword_t    reg_data_i,
    input  logic [3:0]           intr_status_i,
    input  video_pkg::scan_pos_t scan_pos_i,
    output video_pkg::vword_t    reg_data_o,
    output logic [3:0]           intr_signal_o,
    output video_pkg::pf_cfg_t   pf_cfg_o
);
    import video_pkg::*;

    logic last_visible;                         // counters on final visible pixel

    assign last_visible = scan_pos_i.h_visible && scan_pos_i.v_visible
                       && (scan_pos_i.h_count == coord_t'(H_VISIBLE - 1))
                       && (scan_pos_i.v_count == coord_t'(V_VISIBLE - 1));

    // register writes and interrupt pulses
    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_signal_o       <= 4'b0;
            pf_cfg_o.border     <= 8'h08;       // dark grey, shows the core is alive
            pf_cfg_o.colorbase  <= '0;
            pf_cfg_o.blank      <= 1'b0;
            pf_cfg_o.win_left   <= '0;
            pf_cfg_o.win_right  <= coord_t'(H_VISIBLE);
            pf_cfg_o.win_top    <= '0;
            pf_cfg_o.win_bottom <= coord_t'(V_VISIBLE);
            pf_cfg_o.start_addr <= '0;
            pf_cfg_o.line_len   <= vaddr_t'(H_VISIBLE / 2);  // two pixels per word
        end else begin
            intr_signal_o <= 4'b0;              // pulses last one cycle
            if (reg_wr_en_i) begin
                case (reg_num_i)
                    XR_VID_CTRL: begin
                        pf_cfg_o.border <= reg_data_i[15:8];
                        intr_signal_o   <= reg_data_i[3:0];
                    end
                    XR_VID_LEFT:     pf_cfg_o.win_left   <= reg_data_i[10:0];
                    XR_VID_RIGHT:    pf_cfg_o.win_right  <= reg_data_i[10:0];
                    XR_VID_TOP:      pf_cfg_o.win_top    <= reg_data_i[10:0];
                    XR_VID_BOTTOM:   pf_cfg_o.win_bottom <= reg_data_i[10:0];
                    XR_PA_GFX_CTRL: begin
                        pf_cfg_o.colorbase <= reg_data_i[15:8];
                        pf_cfg_o.blank     <= reg_data_i[7];
                    end
                    XR_PA_DISP_ADDR: pf_cfg_o.start_addr <= reg_data_i;
                    XR_PA_LINE_LEN:  pf_cfg_o.line_len   <= reg_data_i;
                    default: begin
                    end
                endcase
            end
            if (last_visible) begin
                intr_signal_o[3] <= 1'b1;       // vertical blank interrupt
            end
        end
    end

    // read decode, one cycle behind reg_num_i
    always_ff @(posedge clk) begin
        case (reg_num_i)
            XR_VID_CTRL:     reg_data_o <= {pf_cfg_o.border, 4'b0, intr_status_i};
            XR_VID_LEFT:     reg_data_o <= {5'b0, pf_cfg_o.win_left};
            XR_VID_RIGHT:    reg_data_o <= {5'b0, pf_cfg_o.win_right};
            XR_VID_TOP:      reg_data_o <= {5'b0, pf_cfg_o.win_top};
            XR_VID_BOTTOM:   reg_data_o <= {5'b0, pf_cfg_o.win_bottom};
            XR_SCANLINE:     reg_data_o <= {~scan_pos_i.v_visible, ~scan_pos_i.h_visible,
                                            3'b0, scan_pos_i.v_count};
            XR_VID_HSIZE:    reg_data_o <= vword_t'(H_VISIBLE);
            XR_VID_VSIZE:    reg_data_o <= vword_t'(V_VISIBLE);
            XR_PA_GFX_CTRL:  reg_data_o <= {pf_cfg_o.colorbase, pf_cfg_o.blank, 7'b0};
            XR_PA_DISP_ADDR: reg_data_o <= pf_cfg_o.start_addr;
            XR_PA_LINE_LEN:  reg_data_o <= pf_cfg_o.line_len;
            default:         reg_data_o <= '0;
        endcase
    end

endmodule

// File: video_timing/video_timing.sv
// video_timing
// Horizontal and vertical scan counters, each with a four state sync
// machine (front porch, sync, back porch, visible). Visible pixels and
// lines come first. Sync and display enable are delayed two cycles so
// they line up with the pixel fetch pipeline.

`timescale 1ns/1ps

module video_timing #(
    parameter int H_VISIBLE  = 640,
    parameter int H_FRONT    = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BACK     = 48,
    parameter int V_VISIBLE  = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter bit H_SYNC_POL = 1'b0,
    parameter bit V_SYNC_POL = 1'b0
) (
    input  logic                 clk,
    input  logic                 reset_i,
    output video_pkg::scan_pos_t scan_pos_o,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 dv_de_o
);
    import video_pkg::*;

    sync_state_e h_state, v_state;
    coord_t      h_count, v_count;
    coord_t      h_end, v_end;                  // last count of current state
    logic        h_adv, v_adv;
    logic        line_end, frame_end;
    logic        hs_d1, vs_d1, de_d1;           // first delay stage, active high

    // last count belonging to a state, counted from the first visible one
    function automatic coord_t state_end(sync_state_e st, int vis, int front,
                                         int sync, int back);
        int last;
        case (st)
            SYNC_VISIBLE: last = vis;
            SYNC_PRE:     last = vis + front;
            SYNC_PULSE:   last = vis + front + sync;
            default:      last = vis + front + sync + back;
        endcase
        return coord_t'(last - 1);
    endfunction

    always_comb begin
        h_end     = state_end(h_state, H_VISIBLE, H_FRONT, H_SYNC, H_BACK);
        v_end     = state_end(v_state, V_VISIBLE, V_FRONT, V_SYNC, V_BACK);
        h_adv     = (h_count == h_end);
        line_end  = h_adv && (h_state == SYNC_POST);
        v_adv     = line_end && (v_count == v_end);     // vertical moves only at line end
        frame_end = v_adv && (v_state == SYNC_POST);
    end

    assign scan_pos_o = '{h_count:   h_count,
                          v_count:   v_count,
                          h_visible: (h_state == SYNC_VISIBLE),
                          v_visible: (v_state == SYNC_VISIBLE),
                          line_end:  line_end,
                          frame_end: frame_end};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state <= SYNC_VISIBLE;                // start on first visible pixel
            v_state <= SYNC_VISIBLE;
            h_count <= '0;
            v_count <= '0;
            hs_d1   <= 1'b0;
            vs_d1   <= 1'b0;
            de_d1   <= 1'b0;
            hsync_o <= ~H_SYNC_POL;
            vsync_o <= ~V_SYNC_POL;
            dv_de_o <= 1'b0;
        end else begin
            h_count <= line_end ? '0 : h_count + coord_t'(1);
            if (line_end) begin
                v_count <= frame_end ? '0 : v_count + coord_t'(1);
            end
            if (h_adv) begin
                h_state <= sync_state_e'(h_state + 2'd1);
            end
            if (v_adv) begin
                v_state <= sync_state_e'(v_state + 2'd1);
            end

            hs_d1   <= (h_state == SYNC_PULSE);
            vs_d1   <= (v_state == SYNC_PULSE);
            de_d1   <= (h_state == SYNC_VISIBLE) && (v_state == SYNC_VISIBLE);
            hsync_o <= hs_d1 ? H_SYNC_POL : ~H_SYNC_POL;   // polarity applied at output
            vsync_o <= vs_d1 ? V_SYNC_POL : ~V_SYNC_POL;
            dv_de_o <= de_d1;
        end
    end

endmodule

// File: common/video_pkg.sv
// video_pkg
// Shared definitions for the video generation core: register numbers,
// vector types for coordinates, addresses and colours, the per-axis sync
// state encoding and the structs that carry scan position and playfield
// configuration between blocks.

package video_pkg;

    typedef logic [10:0] coord_t;       // pixel or line count
    typedef logic [15:0] vaddr_t;       // video RAM word address
    typedef logic [15:0] vword_t;       // video RAM or register word
    typedef logic [7:0]  color_t;       // palette colour index
    typedef logic [4:0]  reg_num_t;     // config register number

    // one per axis, advances cyclically in this order
    typedef enum logic [1:0] {
        SYNC_PRE     = 2'd0,            // front porch
        SYNC_PULSE   = 2'd1,            // sync pulse
        SYNC_POST    = 2'd2,            // back porch
        SYNC_VISIBLE = 2'd3             // active area
    } sync_state_e;

    // config register map
    localparam reg_num_t XR_VID_CTRL     = 5'd0;    // border colour, interrupt bits
    localparam reg_num_t XR_VID_LEFT     = 5'd1;    // window left edge
    localparam reg_num_t XR_VID_RIGHT    = 5'd2;    // window right edge (exclusive)
    localparam reg_num_t XR_VID_TOP      = 5'd3;    // window top line
    localparam reg_num_t XR_VID_BOTTOM   = 5'd4;    // window bottom line (exclusive)
    localparam reg_num_t XR_SCANLINE     = 5'd5;    // read only, blank flags and line
    localparam reg_num_t XR_VID_HSIZE    = 5'd6;    // read only, visible width
    localparam reg_num_t XR_VID_VSIZE    = 5'd7;    // read only, visible height
    localparam reg_num_t XR_PA_GFX_CTRL  = 5'd8;    // colour base, blank
    localparam reg_num_t XR_PA_DISP_ADDR = 5'd9;    // bitmap start address
    localparam reg_num_t XR_PA_LINE_LEN  = 5'd10;   // words per bitmap line

    // current counter position and the events derived from it
    typedef struct packed {
        coord_t h_count;                // 0 is the first visible pixel
        coord_t v_count;                // 0 is the first visible line
        logic   h_visible;
        logic   v_visible;
        logic   line_end;               // last cycle of a line
        logic   frame_end;              // last cycle of a frame
    } scan_pos_t;

    // playfield settings as held by the register block
    typedef struct packed {
        color_t border;
        color_t colorbase;              // XOR'd into each bitmap byte
        logic   blank;                  // show border only
        coord_t win_left;
        coord_t win_right;
        coord_t win_top;
        coord_t win_bottom;
        vaddr_t start_addr;             // word address of first bitmap line
        vaddr_t line_len;               // words between bitmap lines
    } pf_cfg_t;

endpackage
